// File: files.f
+incdir+logic
logic/icache_bypass_pkg.sv
logic/bypass_port_ctrl.sv
logic/bypass_req_arbiter.sv
logic/bypass_rsp_order.sv
logic/icache_bypass.sv
dv/fill_mem_model.sv
dv/icache_bypass_assert.sv
dv/icache_bypass_tb.sv

// File: dv/icache_bypass_tb.sv
// Testbench for the uncached instruction-fetch path
// Applies a table of fetch rows to the ports, checks every returned word and
// error flag against the line data rule, and checks that ports go idle

`include "icache_bypass_config.svh"

module icache_bypass_tb;

  localparam int          NR_PORTS   = `ICB_NR_FETCH_PORTS;
  localparam int          NR_ROWS    = 9;
  localparam int          CLK_PERIOD = 4;
  localparam logic [31:0] DATA_XOR   = 32'hA5A5_0000;

  logic clk;
  logic rst_n;

  logic [NR_PORTS-1:0]                            inst_valid;
  icache_bypass_pkg::fetch_addr_t [NR_PORTS-1:0] inst_addr;
  logic [NR_PORTS-1:0]                            inst_ready;
  icache_bypass_pkg::fetch_data_t [NR_PORTS-1:0] inst_data;
  logic [NR_PORTS-1:0]                            inst_error;

  logic                           fill_req_valid;
  icache_bypass_pkg::fetch_addr_t fill_req_addr;
  logic                           fill_req_ready;
  logic                           fill_rsp_valid;
  icache_bypass_pkg::line_data_t  fill_rsp_data;
  logic                           fill_rsp_error;

  // Stimulus table with the expected word and error per port
  icache_bypass_pkg::port_mask_t  row_mask  [NR_ROWS];
  icache_bypass_pkg::fetch_addr_t row_addr  [NR_ROWS][NR_PORTS];
  icache_bypass_pkg::fetch_data_t row_data  [NR_ROWS][NR_PORTS];
  logic                           row_error [NR_ROWS][NR_PORTS];

  icache_bypass_pkg::bypass_state_e port_state [NR_PORTS];
  int                               assert_fails [NR_PORTS];

  int errors;
  int checks;

  icache_bypass uut (
    .clk_i            ( clk            ),
    .rst_n_i          ( rst_n          ),
    .inst_valid_i     ( inst_valid     ),
    .inst_addr_i      ( inst_addr      ),
    .inst_ready_o     ( inst_ready     ),
    .inst_data_o      ( inst_data      ),
    .inst_error_o     ( inst_error     ),
    .fill_req_valid_o ( fill_req_valid ),
    .fill_req_addr_o  ( fill_req_addr  ),
    .fill_req_ready_i ( fill_req_ready ),
    .fill_rsp_valid_i ( fill_rsp_valid ),
    .fill_rsp_data_i  ( fill_rsp_data  ),
    .fill_rsp_error_i ( fill_rsp_error )
  );

  fill_mem_model #(
    .DATA_XOR ( DATA_XOR ),
    .SEED     ( 16'd10   )
  ) i_mem (
    .clk_i            ( clk            ),
    .fill_req_valid_i ( fill_req_valid ),
    .fill_req_addr_i  ( fill_req_addr  ),
    .fill_req_ready_o ( fill_req_ready ),
    .fill_rsp_valid_o ( fill_rsp_valid ),
    .fill_rsp_data_o  ( fill_rsp_data  ),
    .fill_rsp_error_o ( fill_rsp_error )
  );

  for (genvar g = 0; g < NR_PORTS; g++) begin : gen_state
    assign port_state[g]   = uut.gen_port[g].i_port_ctrl.state_q;
    assign assert_fails[g] = uut.gen_port[g].i_port_ctrl.i_assert.fail_cnt;
  end

  initial begin
    clk = 1'b0;
  end

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Word k of line L is (L + 4k) xor the data pattern
  function automatic icache_bypass_pkg::fetch_data_t rule_word(
    input icache_bypass_pkg::fetch_addr_t a
  );
    icache_bypass_pkg::fetch_addr_t line;
    int                             k;
    line = {a[31:icache_bypass_pkg::LINE_ALIGN], {icache_bypass_pkg::LINE_ALIGN{1'b0}}};
    k    = int'(a[icache_bypass_pkg::LINE_ALIGN-1:icache_bypass_pkg::FETCH_ALIGN]);
    return (line + 4 * k) ^ DATA_XOR;
  endfunction

  // Start address of the line that holds a byte address
  function automatic icache_bypass_pkg::fetch_addr_t line_addr(
    input icache_bypass_pkg::fetch_addr_t a
  );
    return (a >> icache_bypass_pkg::LINE_ALIGN) << icache_bypass_pkg::LINE_ALIGN;
  endfunction

  task automatic add_row(input int r, input icache_bypass_pkg::port_mask_t m,
                         input icache_bypass_pkg::fetch_addr_t a0,
                         input icache_bypass_pkg::fetch_addr_t a1,
                         input icache_bypass_pkg::fetch_addr_t a2,
                         input icache_bypass_pkg::fetch_addr_t a3);
    icache_bypass_pkg::fetch_addr_t a [NR_PORTS];
    a = '{a0, a1, a2, a3};
    row_mask[r] = m;
    for (int p = 0; p < NR_PORTS; p++) begin
      row_addr[r][p]  = a[p];
      row_data[r][p]  = rule_word(a[p]);
      row_error[r][p] = (a[p][31:28] == 4'hF);
    end
  endtask

  task automatic build_table();
    add_row(0, 4'b0001, 32'h0000_1000, 32'h0, 32'h0, 32'h0);
    add_row(1, 4'b0010, 32'h0, 32'h0000_1004, 32'h0, 32'h0);
    add_row(2, 4'b0100, 32'h0, 32'h0, 32'h0000_2008, 32'h0);
    add_row(3, 4'b1000, 32'h0, 32'h0, 32'h0, 32'h0000_300C);
    add_row(4, 4'b0001, 32'hF000_0104, 32'h0, 32'h0, 32'h0);
    add_row(5, 4'b1111, 32'h0000_4000, 32'h0000_4014, 32'h0000_5028, 32'h0000_603C);
    add_row(6, 4'b1111, 32'hF000_0010, 32'h1234_5678, 32'hABCD_EF04, 32'h0000_0FFC);
    add_row(7, 4'b0101, 32'h8000_0008, 32'h0, 32'h7FFF_FFF0, 32'h0);
    add_row(8, 4'b1010, 32'h0, 32'hFFFF_FFFC, 32'h0, 32'h0000_0044);
  endtask

  task automatic check_data(input string name, input icache_bypass_pkg::fetch_data_t exp,
                            input icache_bypass_pkg::fetch_data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_error(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_ready(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input icache_bypass_pkg::fetch_addr_t exp,
                            input icache_bypass_pkg::fetch_addr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_port_idle(input string name,
                                 input icache_bypass_pkg::bypass_state_e act);
    icache_bypass_pkg::bypass_state_e exp;
    exp = icache_bypass_pkg::BYP_IDLE;
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t: %s expected %s, got %s", $time, name,
               exp.name(), act.name());
    end
  endtask

  task automatic check_all_idle();
    for (int p = 0; p < NR_PORTS; p++) begin
      check_port_idle($sformatf("gen_port[%0d].state_q", p), port_state[p]);
      check_ready($sformatf("inst_ready_o[%0d]", p), 1'b0, inst_ready[p]);
    end
    check_ready("fill_req_valid_o", 1'b0, fill_req_valid);
  endtask

  // Raise valid on the row's ports and hold each until its ready pulse
  task automatic run_row(input int r);
    icache_bypass_pkg::port_mask_t pending;
    pending = row_mask[r];
    for (int p = 0; p < NR_PORTS; p++) begin
      if (pending[p]) begin
        inst_valid[p] = 1'b1;
        inst_addr[p]  = row_addr[r][p];
      end
    end
    while (pending != '0) begin
      @(negedge clk);
      for (int p = 0; p < NR_PORTS; p++) begin
        if (pending[p] && inst_ready[p]) begin
          check_data($sformatf("inst_data_o[%0d]", p), row_data[r][p], inst_data[p]);
          check_error($sformatf("inst_error_o[%0d]", p), row_error[r][p], inst_error[p]);
          inst_valid[p] = 1'b0;
          pending[p]    = 1'b0;
        end else if (!pending[p]) begin
          check_ready($sformatf("inst_ready_o[%0d]", p), 1'b0, inst_ready[p]);
        end
      end
    end
    @(negedge clk);
    check_all_idle();
  endtask

  // Every fill request must carry the line address of a port that is fetching
  always @(negedge clk) begin
    icache_bypass_pkg::fetch_addr_t exp_addr;
    logic                           found;
    #1;
    if (rst_n && fill_req_valid === 1'b1) begin
      exp_addr = '0;
      found    = 1'b0;
      for (int p = 0; p < NR_PORTS; p++) begin
        if (inst_valid[p] && !found) begin
          exp_addr = line_addr(inst_addr[p]);
          found    = (exp_addr === fill_req_addr);
        end
      end
      check_addr("fill_req_addr_o", exp_addr, fill_req_addr);
    end
  end

  initial begin
    #(CLK_PERIOD * (NR_ROWS * 60 + 5));
    $display("Watchdog expired: fetches did not complete within %0d cycles", NR_ROWS * 60);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    errors     = 0;
    checks     = 0;
    rst_n      = 1'b0;
    inst_valid = '0;
    inst_addr  = '0;
    build_table();
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    check_all_idle();
    for (int r = 0; r < NR_ROWS; r++) begin
      run_row(r);
    end
    for (int p = 0; p < NR_PORTS; p++) begin
      if (assert_fails[p] != 0) begin
        $display("Port %0d controller assertions failed %0d times", p, assert_fails[p]);
        errors += assert_fails[p];
      end
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: dv/icache_bypass_assert.sv
// Concurrent checks on one bypass port controller
// Bound into every bypass_port_ctrl instance from this file

module icache_bypass_assert (
  input logic                           clk_i,
  input logic                           rst_n_i,
  input logic                           inst_ready_o,
  input logic                           order_full_i,
  input logic                           port_req_valid_o,
  input icache_bypass_pkg::fetch_addr_t port_req_addr_o,
  input logic                           port_grant_i
);

  // Number of assertion failures seen on this port
  int fail_cnt = 0;

  // Completion is a single-cycle pulse
  a_ready_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    inst_ready_o |=> !inst_ready_o)
    else begin
      fail_cnt++;
      $error("inst_ready_o high for two cycles in a row");
    end

  // Neither a new request nor a grant while the order FIFO has no free slot
  a_no_req_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (port_req_valid_o || port_grant_i) |-> !order_full_i)
    else begin
      fail_cnt++;
      $error("port request or grant while the order FIFO is full");
    end

  // A waiting request keeps its line address until it is granted
  a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (port_req_valid_o && !port_grant_i) |=> $stable(port_req_addr_o))
    else begin
      fail_cnt++;
      $error("port_req_addr_o changed before grant");
    end

endmodule

bind bypass_port_ctrl icache_bypass_assert i_assert (
  .clk_i            ( clk_i            ),
  .rst_n_i          ( rst_n_i          ),
  .inst_ready_o     ( inst_ready_o     ),
  .order_full_i     ( order_full_i     ),
  .port_req_valid_o ( port_req_valid_o ),
  .port_req_addr_o  ( port_req_addr_o  ),
  .port_grant_i     ( port_grant_i     )
);

// File: dv/fill_mem_model.sv
// Line-fill memory model for the bypass fetch testbench
// Accepts requests with pseudo-random back-pressure and answers them in order
// after a random delay of 0 to 3 extra cycles

`include "icache_bypass_config.svh"

module fill_mem_model #(
  parameter logic [31:0] DATA_XOR = 32'hA5A5_0000,
  parameter logic [15:0] SEED     = 16'd10
) (
  input  logic                           clk_i,
  input  logic                           fill_req_valid_i,
  input  icache_bypass_pkg::fetch_addr_t fill_req_addr_i,
  output logic                           fill_req_ready_o,
  output logic                           fill_rsp_valid_o,
  output icache_bypass_pkg::line_data_t  fill_rsp_data_o,
  output logic                           fill_rsp_error_o
);

  localparam int WORDS = `ICB_LINE_WIDTH / `ICB_FETCH_DW;

  logic [15:0]                    lfsr_q;
  icache_bypass_pkg::fetch_addr_t pend_addr[$];
  int                             pend_due[$];
  int                             cyc;

  // Galois LFSR, taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic lsb;
    lsb = s[0];
    s   = s >> 1;
    if (lsb) begin
      s = s ^ 16'hB400;
    end
    return s;
  endfunction

  task automatic take_bit(output logic b);
    b      = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
  endtask

  // Word k of line L holds (L + 4k) xor the data pattern
  function automatic icache_bypass_pkg::line_data_t make_line(
    input icache_bypass_pkg::fetch_addr_t addr
  );
    icache_bypass_pkg::line_data_t  line;
    icache_bypass_pkg::fetch_addr_t base;
    base = {addr[31:icache_bypass_pkg::LINE_ALIGN], {icache_bypass_pkg::LINE_ALIGN{1'b0}}};
    for (int k = 0; k < WORDS; k++) begin
      line[k*`ICB_FETCH_DW +: `ICB_FETCH_DW] = (base + 4 * k) ^ DATA_XOR;
    end
    return line;
  endfunction

  initial begin
    lfsr_q           = SEED;
    cyc              = 0;
    fill_req_ready_o = 1'b0;
    fill_rsp_valid_o = 1'b0;
    fill_rsp_data_o  = '0;
    fill_rsp_error_o = 1'b0;
  end

  always @(negedge clk_i) begin
    logic b_rdy;
    logic b_hi;
    logic b_lo;
    cyc++;
    // Only the oldest request may answer, which keeps responses in order
    if (pend_due.size() > 0 && pend_due[0] <= cyc) begin
      fill_rsp_valid_o = 1'b1;
      fill_rsp_data_o  = make_line(pend_addr[0]);
      fill_rsp_error_o = (pend_addr[0][31:28] == 4'hF);
      void'(pend_addr.pop_front());
      void'(pend_due.pop_front());
    end else begin
      fill_rsp_valid_o = 1'b0;
      fill_rsp_data_o  = '0;
      fill_rsp_error_o = 1'b0;
    end
    take_bit(b_rdy);
    fill_req_ready_o = b_rdy;
    // Request side is stable well before the next rising edge
    #1;
    if (fill_req_valid_i && fill_req_ready_o) begin
      take_bit(b_hi);
      take_bit(b_lo);
      pend_addr.push_back(fill_req_addr_i);
      pend_due.push_back(cyc + 1 + int'({b_hi, b_lo}));
    end
  end

endmodule

// File: logic/icache_bypass.sv
// Top level of the uncached instruction-fetch path
// One controller per fetch port, a round-robin arbiter toward the line-fill
// memory and an order tracker that steers fill responses back to their port

`include "icache_bypass_config.svh"

module icache_bypass (
  input  logic                                                     clk_i,
  input  logic                                                     rst_n_i,

  input  logic [`ICB_NR_FETCH_PORTS-1:0]                           inst_valid_i,
  input  icache_bypass_pkg::fetch_addr_t [`ICB_NR_FETCH_PORTS-1:0] inst_addr_i,
  output logic [`ICB_NR_FETCH_PORTS-1:0]                           inst_ready_o,
  output icache_bypass_pkg::fetch_data_t [`ICB_NR_FETCH_PORTS-1:0] inst_data_o,
  output logic [`ICB_NR_FETCH_PORTS-1:0]                           inst_error_o,

  output logic                                                     fill_req_valid_o,
  output icache_bypass_pkg::fetch_addr_t                           fill_req_addr_o,
  input  logic                                                     fill_req_ready_i,

  input  logic                                                     fill_rsp_valid_i,
  input  icache_bypass_pkg::line_data_t                            fill_rsp_data_i,
  input  logic                                                     fill_rsp_error_i
);

  icache_bypass_pkg::port_mask_t                            port_req_valid;
  icache_bypass_pkg::fetch_addr_t [`ICB_NR_FETCH_PORTS-1:0] port_req_addr;
  icache_bypass_pkg::port_mask_t                            port_grant;
  icache_bypass_pkg::port_mask_t                            rsp_hit;
  logic                                                     order_full;

  for (genvar i = 0; i < `ICB_NR_FETCH_PORTS; i++) begin : gen_port
    bypass_port_ctrl i_port_ctrl (
      .clk_i            ( clk_i              ),
      .rst_n_i          ( rst_n_i            ),
      .inst_valid_i     ( inst_valid_i[i]    ),
      .inst_addr_i      ( inst_addr_i[i]     ),
      .inst_ready_o     ( inst_ready_o[i]    ),
      .inst_data_o      ( inst_data_o[i]     ),
      .inst_error_o     ( inst_error_o[i]    ),
      .order_full_i     ( order_full         ),
      .port_req_valid_o ( port_req_valid[i]  ),
      .port_req_addr_o  ( port_req_addr[i]   ),
      .port_grant_i     ( port_grant[i]      ),
      // The whole line goes to every port, rsp_hit picks the owner
      .rsp_hit_i        ( rsp_hit[i]         ),
      .rsp_line_i       ( fill_rsp_data_i    ),
      .rsp_error_i      ( fill_rsp_error_i   )
    );
  end

  bypass_req_arbiter i_req_arbiter (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .port_req_valid_i ( port_req_valid   ),
    .port_req_addr_i  ( port_req_addr    ),
    .port_grant_o     ( port_grant       ),
    .fill_req_valid_o ( fill_req_valid_o ),
    .fill_req_addr_o  ( fill_req_addr_o  ),
    .fill_req_ready_i ( fill_req_ready_i )
  );

  // The grant mask only carries a bit on an accepted request, so it doubles
  // as the push into the order tracker
  bypass_rsp_order i_rsp_order (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .grant_mask_i     ( port_grant       ),
    .order_full_o     ( order_full       ),
    .fill_rsp_valid_i ( fill_rsp_valid_i ),
    .rsp_hit_o        ( rsp_hit          )
  );

endmodule

// File: logic/bypass_rsp_order.sv
// In-order response tracker for the line-fill interface
// Records the grant mask of every accepted fill request and routes each fill
// response to the port at the head, raising full when no slot is left

`include "icache_bypass_config.svh"

module bypass_rsp_order (
  input  logic                          clk_i,
  input  logic                          rst_n_i,

  input  icache_bypass_pkg::port_mask_t grant_mask_i,
  output logic                          order_full_o,

  input  logic                          fill_rsp_valid_i,
  output icache_bypass_pkg::port_mask_t rsp_hit_o
);

  localparam int DEPTH = `ICB_ORDER_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  icache_bypass_pkg::port_mask_t mem_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;
  logic             empty;

  icache_bypass_pkg::port_mask_t head_mask;
  icache_bypass_pkg::port_idx_t  head_idx;

  assign empty        = (count_q == '0);
  assign order_full_o = (count_q == CNT_W'(DEPTH));

  // A nonzero grant mask means the memory took a request this cycle
  assign push = |grant_mask_i;
  assign pop  = fill_rsp_valid_i && !empty;

  assign head_mask = mem_q[rd_ptr_q];

  // One-hot head entry to a binary port number
  always_comb begin
    head_idx = '0;
    for (int i = 0; i < $bits(head_mask); i++) begin
      if (head_mask[i]) begin
        head_idx = head_idx | icache_bypass_pkg::port_idx_t'(i);
      end
    end
  end

  always_comb begin
    rsp_hit_o = '0;
    if (pop) begin
      rsp_hit_o[head_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= grant_mask_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the fill level unchanged
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// File: logic/bypass_req_arbiter.sv
// Round-robin arbiter between the port controllers and the line-fill memory
// Forwards the chosen port's line address and grants that port only when the
// memory accepts the request

`include "icache_bypass_config.svh"

module bypass_req_arbiter (
  input  logic                                                     clk_i,
  input  logic                                                     rst_n_i,

  input  icache_bypass_pkg::port_mask_t                            port_req_valid_i,
  input  icache_bypass_pkg::fetch_addr_t [`ICB_NR_FETCH_PORTS-1:0] port_req_addr_i,
  output icache_bypass_pkg::port_mask_t                            port_grant_o,

  output logic                                                     fill_req_valid_o,
  output icache_bypass_pkg::fetch_addr_t                           fill_req_addr_o,
  input  logic                                                     fill_req_ready_i
);

  localparam int NR_PORTS = `ICB_NR_FETCH_PORTS;

  icache_bypass_pkg::port_idx_t rr_ptr_q;
  icache_bypass_pkg::port_idx_t win_idx;
  icache_bypass_pkg::port_idx_t next_ptr;
  logic                         accept;

  // Scan from the pointer downwards in priority, so the last hit written is
  // the first requesting port at or after the pointer
  always_comb begin
    int cand;
    win_idx = rr_ptr_q;
    for (int i = NR_PORTS - 1; i >= 0; i--) begin
      cand = (int'(rr_ptr_q) + i) % NR_PORTS;
      if (port_req_valid_i[cand]) begin
        win_idx = icache_bypass_pkg::port_idx_t'(cand);
      end
    end
  end

  assign fill_req_valid_o = |port_req_valid_i;
  assign fill_req_addr_o  = port_req_addr_i[win_idx];
  assign accept           = fill_req_valid_o && fill_req_ready_i;

  // Grant is a one-hot mask, present only on an accepted request
  always_comb begin
    port_grant_o = '0;
    if (accept) begin
      port_grant_o[win_idx] = 1'b1;
    end
  end

  assign next_ptr = icache_bypass_pkg::port_idx_t'((int'(win_idx) + 1) % NR_PORTS);

  // Priority moves past the winner so it goes last next time
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_ptr_q <= '0;
    end else if (accept) begin
      rr_ptr_q <= next_ptr;
    end
  end

endmodule

// File: logic/bypass_port_ctrl.sv
// Bypass controller for a single fetch port
// Turns a held fetch into one line-aligned fill request, then picks the
// addressed word out of the returned line and presents it for one cycle

module bypass_port_ctrl (
  input  logic                           clk_i,
  input  logic                           rst_n_i,

  input  logic                           inst_valid_i,
  input  icache_bypass_pkg::fetch_addr_t inst_addr_i,
  output logic                           inst_ready_o,
  output icache_bypass_pkg::fetch_data_t inst_data_o,
  output logic                           inst_error_o,

  input  logic                           order_full_i,

  output logic                           port_req_valid_o,
  output icache_bypass_pkg::fetch_addr_t port_req_addr_o,
  input  logic                           port_grant_i,

  input  logic                           rsp_hit_i,
  input  icache_bypass_pkg::line_data_t  rsp_line_i,
  input  logic                           rsp_error_i
);

  localparam int WORD_W   = $bits(icache_bypass_pkg::fetch_data_t);
  localparam int OFFS_W   = icache_bypass_pkg::LINE_ALIGN - icache_bypass_pkg::FETCH_ALIGN;

  icache_bypass_pkg::bypass_state_e state_q, state_d;

  logic [OFFS_W-1:0]              word_off;
  icache_bypass_pkg::line_data_t  shifted_line;
  icache_bypass_pkg::fetch_data_t data_q;
  logic                           error_q;
  logic                           capture;

  // Line-aligned request address, the core keeps inst_addr_i stable meanwhile
  assign port_req_addr_o = {inst_addr_i[$bits(inst_addr_i)-1:icache_bypass_pkg::LINE_ALIGN],
                            {icache_bypass_pkg::LINE_ALIGN{1'b0}}};

  // Word offset inside the line selects which word of the fill we keep
  assign word_off     = inst_addr_i[icache_bypass_pkg::LINE_ALIGN-1:icache_bypass_pkg::FETCH_ALIGN];
  assign shifted_line = rsp_line_i >> (word_off * WORD_W);

  always_comb begin
    state_d          = state_q;
    port_req_valid_o = 1'b0;
    inst_ready_o     = 1'b0;
    capture          = 1'b0;
    case (state_q)
      icache_bypass_pkg::BYP_IDLE: begin
        if (inst_valid_i) begin
          state_d = icache_bypass_pkg::BYP_REQUEST;
        end
      end
      icache_bypass_pkg::BYP_REQUEST: begin
        // Only ask for the bus while the order tracker can take another entry
        if (!order_full_i) begin
          port_req_valid_o = 1'b1;
          if (port_grant_i) begin
            state_d = icache_bypass_pkg::BYP_WAIT;
          end
        end
      end
      icache_bypass_pkg::BYP_WAIT: begin
        if (rsp_hit_i) begin
          capture = 1'b1;
          state_d = icache_bypass_pkg::BYP_PRESENT;
        end
      end
      icache_bypass_pkg::BYP_PRESENT: begin
        // Registered word is shown for exactly this one cycle
        inst_ready_o = 1'b1;
        state_d      = icache_bypass_pkg::BYP_IDLE;
      end
      default: begin
        state_d = icache_bypass_pkg::BYP_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= icache_bypass_pkg::BYP_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      data_q  <= shifted_line[WORD_W-1:0];
      error_q <= rsp_error_i;
    end
  end

  assign inst_data_o  = data_q;
  assign inst_error_o = error_q;

endmodule

// File: logic/icache_bypass_pkg.sv
// Shared types and alignment constants for the bypass fetch path
// Modules reference these by scoped name, sizes come from the config header

`include "icache_bypass_config.svh"

package icache_bypass_pkg;

  // Fetch side address and instruction word
  typedef logic [`ICB_FETCH_AW-1:0] fetch_addr_t;
  typedef logic [`ICB_FETCH_DW-1:0] fetch_data_t;

  // One fill line, several fetch words wide
  typedef logic [`ICB_LINE_WIDTH-1:0] line_data_t;

  // One bit per port, used both one-hot and as a request vector
  typedef logic [`ICB_NR_FETCH_PORTS-1:0] port_mask_t;

  // Binary port number
  typedef logic [$clog2(`ICB_NR_FETCH_PORTS)-1:0] port_idx_t;

  // Byte offset bits within a line and within a word
  localparam int LINE_ALIGN  = $clog2(`ICB_LINE_WIDTH / 8);
  localparam int FETCH_ALIGN = $clog2(`ICB_FETCH_DW / 8);

  // Per-port bypass controller states
  typedef enum logic [1:0] {
    BYP_IDLE,
    BYP_REQUEST,
    BYP_WAIT,
    BYP_PRESENT
  } bypass_state_e;

endpackage

// File: logic/icache_bypass_config.svh
// Size configuration for the uncached instruction-fetch path
// Included by the package and by every module that sizes ports or storage

`ifndef ICACHE_BYPASS_CONFIG_SVH
`define ICACHE_BYPASS_CONFIG_SVH

// Number of independent fetch ports
`define ICB_NR_FETCH_PORTS 4

// Fetch address and instruction word widths
`define ICB_FETCH_AW 32
`define ICB_FETCH_DW 32

// Width of one line returned by the fill memory
`define ICB_LINE_WIDTH 128

// Fill requests that may be in flight, smaller than the port count on purpose
`define ICB_ORDER_DEPTH 2

`endif
